// File: rtl/image_pkg.sv
package image_pkg;

  // ------------------------------------------------------------
  // image geometry
  // ------------------------------------------------------------
  localparam int img_w    = 16;
  localparam int img_h    = 8;
  localparam int n_layers = 4;

  typedef logic signed [7:0] pixel_t;
  typedef pixel_t [img_w-1:0] layer_row_t;  // pixel 0 sits in the low byte
  typedef logic [$clog2(n_layers)-1:0] layer_idx_t;

  typedef logic [2:0] row_idx_t;
  typedef logic [3:0] col_idx_t;

  // one row across all DoG layers, as the row memory returns it
  typedef struct packed {
    layer_row_t layer0;
    layer_row_t layer1;
    layer_row_t layer2;
    layer_row_t layer3;
  } dog_row_t;

  typedef struct packed {
    dog_row_t top;
    dog_row_t mid;
    dog_row_t btm;
  } window_t;

  function automatic layer_row_t get_layer(dog_row_t r, layer_idx_t idx);
    layer_row_t lr;
    case (idx)
      2'd0:    lr = r.layer0;
      2'd1:    lr = r.layer1;
      2'd2:    lr = r.layer2;
      default: lr = r.layer3;
    endcase
    return lr;
  endfunction

endpackage

// File: rtl/keypoint_pkg.sv
package keypoint_pkg;

  // ------------------------------------------------------------
  // keypoint record and detection thresholds
  // ------------------------------------------------------------
  typedef struct packed {
    logic [2:0] row;
    logic [3:0] col;
    logic       layer;   // 0 for centre layer 1, 1 for centre layer 2
    logic       is_min;
  } kp_rec_t;

  localparam int contrast_th = 4;   // centre magnitude must exceed this
  localparam int edge_r      = 10;  // principal curvature ratio limit
  localparam int kp_depth    = 256;

  typedef logic [$clog2(kp_depth)-1:0] kp_addr_t;
  typedef logic [$clog2(kp_depth):0]   kp_count_t;

  typedef enum logic [1:0] {
    ln_idle,
    ln_request,
    ln_release
  } lane_state_t;

  typedef enum logic [2:0] {
    cs_idle,
    cs_fetch,
    cs_shift,
    cs_column,
    cs_wait_lanes,
    cs_next_row,
    cs_finish
  } ctrl_state_t;

endpackage

// File: rtl/row_window.sv
`timescale 1ns/1ps

module row_window import image_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     load,
  input  dog_row_t row_data,
  output window_t  win
);

  // the newest row enters at the bottom of the three-row window
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win <= '0;
    end else if (load) begin
      win.top <= win.mid;
      win.mid <= win.btm;
      win.btm <= row_data;  // arrives one cycle after the read
    end
  end

endmodule

// File: rtl/extremum_detect.sv
`timescale 1ns/1ps

module extremum_detect import image_pkg::*; import keypoint_pkg::*; (
  input  window_t  win,
  input  col_idx_t col,
  input  logic     centre_layer,
  output logic     is_ext,
  output logic     is_min
);

  dog_row_t rows [3];

  assign rows[0] = win.top;
  assign rows[1] = win.mid;
  assign rows[2] = win.btm;

  // compare the centre against the full 3x3x3 cube around it
  always_comb begin
    layer_row_t lr;
    pixel_t     centre;
    pixel_t     nb;
    logic       gt_all;
    logic       lt_all;
    int         mag;
    lr     = get_layer(win.mid, layer_idx_t'(centre_layer + 1));
    centre = lr[col];
    gt_all = 1'b1;
    lt_all = 1'b1;
    for (int l = 0; l < 3; l++) begin
      for (int r = 0; r < 3; r++) begin
        lr = get_layer(rows[r], layer_idx_t'(l + centre_layer));
        for (int c = -1; c <= 1; c++) begin
          nb = lr[col_idx_t'(col + c)];
          if (!(l == 1 && r == 1 && c == 0)) begin
            if (!(centre > nb)) gt_all = 1'b0;
            if (!(centre < nb)) lt_all = 1'b0;
          end
        end
      end
    end
    mag = (centre < 0) ? -int'(centre) : int'(centre);
    is_ext = (gt_all || lt_all) && (mag > contrast_th);  // weak extrema are noise
    is_min = lt_all;
  end

endmodule

// File: rtl/edge_reject.sv
`timescale 1ns/1ps

module edge_reject import image_pkg::*; import keypoint_pkg::*; (
  input  window_t  win,
  input  col_idx_t col,
  input  logic     centre_layer,
  output logic     keep
);

  layer_row_t up;
  layer_row_t ctr;
  layer_row_t dn;
  col_idx_t   cl;
  col_idx_t   cr;

  assign up  = get_layer(win.top, layer_idx_t'(centre_layer + 1));
  assign ctr = get_layer(win.mid, layer_idx_t'(centre_layer + 1));
  assign dn  = get_layer(win.btm, layer_idx_t'(centre_layer + 1));
  assign cl  = col - 1'b1;
  assign cr  = col + 1'b1;

  // Hessian ratio test scaled by 16 so dxy needs no division by four
  always_comb begin
    int dxx;
    int dyy;
    int dxy;
    int tr;
    int det4;
    dxx  = int'(ctr[cr]) + int'(ctr[cl]) - 2 * int'(ctr[col]);
    dyy  = int'(dn[col]) + int'(up[col]) - 2 * int'(ctr[col]);
    dxy  = int'(dn[cr]) + int'(up[cl]) - int'(dn[cl]) - int'(up[cr]);
    tr   = dxx + dyy;
    det4 = 16 * dxx * dyy - dxy * dxy;  // all terms fit in 32 bits for 8-bit pixels
    keep = (det4 > 0) && (16 * edge_r * tr * tr < (edge_r + 1) * (edge_r + 1) * det4);
  end

endmodule

// File: rtl/scan_lane.sv
`timescale 1ns/1ps

module scan_lane import image_pkg::*; import keypoint_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  window_t  win,
  input  row_idx_t centre_row,
  input  col_idx_t centre_col,
  input  logic     col_go,
  input  logic     filter_on,
  input  logic     lane_id,
  output logic     busy,
  output logic     req,
  output kp_rec_t  rec,
  input  logic     ack
);

  lane_state_t state;
  logic        is_ext;
  logic        is_min;
  logic        keep;
  logic        hit;

  extremum_detect u_ext (
    .win          (win),
    .col          (centre_col),
    .centre_layer (lane_id),
    .is_ext       (is_ext),
    .is_min       (is_min)
  );

  edge_reject u_edge (
    .win          (win),
    .col          (centre_col),
    .centre_layer (lane_id),
    .keep         (keep)
  );

  assign hit = is_ext && (keep || !filter_on);

  // ------------------------------------------------------------
  // four-phase requester towards the store
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ln_idle;
    end else begin
      case (state)
        ln_idle:    if (col_go && hit) state <= ln_request;
        ln_request: if (ack) state <= ln_release;
        ln_release: if (!ack) state <= ln_idle;  // store has closed the handshake
        default:    state <= ln_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (col_go && hit) begin
      rec.row    <= centre_row;
      rec.col    <= centre_col;
      rec.layer  <= lane_id;
      rec.is_min <= is_min;
    end
  end

  assign req  = (state == ln_request);
  assign busy = (state != ln_idle);

endmodule

// File: rtl/keypoint_store.sv
`timescale 1ns/1ps

module keypoint_store import keypoint_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      clear,
  input  logic [1:0] req,
  input  kp_rec_t   rec0,
  input  kp_rec_t   rec1,
  output logic [1:0] ack,
  input  kp_addr_t  rd_addr,
  output kp_rec_t   rd_data,
  output kp_count_t count
);

  kp_rec_t    mem [kp_depth];
  logic [1:0] grant_new;
  kp_rec_t    wr_rec;

  // a new grant only starts when no handshake is open and lane 0 wins ties
  always_comb begin
    grant_new = 2'b00;
    if (ack == 2'b00) begin
      if (req[0]) begin
        grant_new = 2'b01;
      end else if (req[1]) begin
        grant_new = 2'b10;
      end
    end
  end

  assign wr_rec = grant_new[0] ? rec0 : rec1;

  // ack doubles as the held grant
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack <= 2'b00;
    end else if (ack == 2'b00) begin
      ack <= grant_new;
    end else if ((ack & req) == 2'b00) begin
      ack <= 2'b00;  // granted lane has dropped req
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (grant_new != 2'b00) begin
      count <= count + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (grant_new != 2'b00) begin
      mem[kp_addr_t'(count)] <= wr_rec;
    end
  end

  assign rd_data = mem[rd_addr];

endmodule

// File: rtl/scan_control.sv
`timescale 1ns/1ps

module scan_control import image_pkg::*; import keypoint_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  logic [1:0] lanes_busy,
  output row_idx_t   row_addr,
  output logic       row_rd,
  output logic       load,
  output logic       col_go,
  output row_idx_t   centre_row,
  output col_idx_t   centre_col,
  output logic       done
);

  ctrl_state_t state;
  row_idx_t    row_cnt;  // the centre row sits one above the last row read
  col_idx_t    col;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= cs_idle;
      row_cnt <= '0;
      col     <= '0;
      done    <= 1'b0;
    end else begin
      case (state)
        cs_idle: begin
          if (start) begin
            row_cnt <= '0;
            done    <= 1'b0;
            state   <= cs_fetch;
          end
        end
        cs_fetch: state <= cs_shift;
        cs_shift: begin
          // the first three rows fill the window before any column is tested
          if (row_cnt < row_idx_t'(2)) begin
            row_cnt <= row_cnt + 1'b1;
            state   <= cs_fetch;
          end else begin
            col   <= col_idx_t'(1);
            state <= cs_column;
          end
        end
        cs_column: state <= cs_wait_lanes;
        cs_wait_lanes: begin
          if (lanes_busy == 2'b00) begin
            if (col == col_idx_t'(img_w - 2)) begin
              state <= cs_next_row;
            end else begin
              col   <= col + 1'b1;
              state <= cs_column;
            end
          end
        end
        cs_next_row: begin
          if (row_cnt == row_idx_t'(img_h - 1)) begin
            state <= cs_finish;
          end else begin
            row_cnt <= row_cnt + 1'b1;
            state   <= cs_fetch;
          end
        end
        cs_finish: begin
          done  <= 1'b1;  // held until the next start
          state <= cs_idle;
        end
        default: state <= cs_idle;
      endcase
    end
  end

  assign row_addr   = row_cnt;
  assign row_rd     = (state == cs_fetch);
  assign load       = (state == cs_shift);
  assign col_go     = (state == cs_column);
  assign centre_row = row_cnt - 1'b1;
  assign centre_col = col;

endmodule

// File: rtl/keypoint_scan_top.sv
`timescale 1ns/1ps

module keypoint_scan_top import image_pkg::*; import keypoint_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start,
  input  logic      filter_on,
  output row_idx_t  row_addr,
  output logic      row_rd,
  input  dog_row_t  row_data,
  output logic      done,
  output kp_count_t kp_count,
  input  kp_addr_t  kp_rd_addr,
  output kp_rec_t   kp_rd_data
);

  logic       load;
  logic       col_go;
  logic [1:0] lanes_busy;
  logic [1:0] kp_req;
  logic [1:0] kp_ack;
  row_idx_t   centre_row;
  col_idx_t   centre_col;
  window_t    win;
  kp_rec_t    rec0;
  kp_rec_t    rec1;

  scan_control u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .lanes_busy (lanes_busy),
    .row_addr   (row_addr),
    .row_rd     (row_rd),
    .load       (load),
    .col_go     (col_go),
    .centre_row (centre_row),
    .centre_col (centre_col),
    .done       (done)
  );

  row_window u_window (
    .clk      (clk),
    .rst_n    (rst_n),
    .load     (load),
    .row_data (row_data),
    .win      (win)
  );

  // lane 0 centres on layer 1, lane 1 on layer 2
  scan_lane u_lane0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .win        (win),
    .centre_row (centre_row),
    .centre_col (centre_col),
    .col_go     (col_go),
    .filter_on  (filter_on),
    .lane_id    (1'b0),
    .busy       (lanes_busy[0]),
    .req        (kp_req[0]),
    .rec        (rec0),
    .ack        (kp_ack[0])
  );

  scan_lane u_lane1 (
    .clk        (clk),
    .rst_n      (rst_n),
    .win        (win),
    .centre_row (centre_row),
    .centre_col (centre_col),
    .col_go     (col_go),
    .filter_on  (filter_on),
    .lane_id    (1'b1),
    .busy       (lanes_busy[1]),
    .req        (kp_req[1]),
    .rec        (rec1),
    .ack        (kp_ack[1])
  );

  keypoint_store u_store (
    .clk     (clk),
    .rst_n   (rst_n),
    .clear   (start),
    .req     (kp_req),
    .rec0    (rec0),
    .rec1    (rec1),
    .ack     (kp_ack),
    .rd_addr (kp_rd_addr),
    .rd_data (kp_rd_data),
    .count   (kp_count)
  );

endmodule

// File: tests/tb_keypoint_scan.sv
`timescale 1ns/1ps

module tb_keypoint_scan
  import image_pkg::*;
  import keypoint_pkg::*;
();

  localparam int clk_period = 10;
  localparam int n_random   = 4;
  localparam int col_cycles = 12;  // both lanes hit and queue at the store
  localparam int scan_cycles = 8 + (img_h - 2) * (3 + (img_w - 2) * col_cycles);
  localparam int read_cycles = 4 * (img_h - 2) * (img_w - 2) + 4;
  localparam int n_scans     = 11 + 2 * n_random;
  localparam longint watchdog_ns = 2 * clk_period * (32 + n_scans * (scan_cycles + read_cycles));

  logic      clk = 1'b0;
  logic      rst_n;
  logic      start;
  logic      filter_on;
  row_idx_t  row_addr;
  logic      row_rd;
  dog_row_t  row_data = '0;
  logic      done;
  kp_count_t kp_count;
  kp_addr_t  kp_rd_addr;
  kp_rec_t   kp_rd_data;

  pixel_t      px [n_layers][img_h][img_w];  // image as the reference model sees it
  dog_row_t    img [img_h];                   // same image packed for the row memory
  kp_rec_t     exp_q [$];
  logic [31:0] rng_state = 32'h9ee83ebe;

  keypoint_scan_top u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .filter_on  (filter_on),
    .row_addr   (row_addr),
    .row_rd     (row_rd),
    .row_data   (row_data),
    .done       (done),
    .kp_count   (kp_count),
    .kp_rd_addr (kp_rd_addr),
    .kp_rd_data (kp_rd_data)
  );

  always #(clk_period / 2) clk = ~clk;

  // row memory answers one cycle after the read
  always @(posedge clk) begin
    if (row_rd) row_data <= img[row_addr];
  end

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift_next();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------
  function automatic int px_at(int l, int r, int c);
    return int'(px[l][r][c]);
  endfunction

  // returns {reported extremum, is minimum}
  function automatic logic [1:0] ext_check(int lc, int r, int c);
    logic gt;
    logic lt;
    int   v;
    int   mag;
    v  = px_at(lc, r, c);
    gt = 1'b1;
    lt = 1'b1;
    for (int dl = -1; dl <= 1; dl++) begin
      for (int dr = -1; dr <= 1; dr++) begin
        for (int dc = -1; dc <= 1; dc++) begin
          if (dl != 0 || dr != 0 || dc != 0) begin
            if (!(v > px_at(lc + dl, r + dr, c + dc))) gt = 1'b0;
            if (!(v < px_at(lc + dl, r + dr, c + dc))) lt = 1'b0;
          end
        end
      end
    end
    mag = (v < 0) ? -v : v;
    return {(gt || lt) && (mag > contrast_th), lt};
  endfunction

  function automatic logic edge_keep(int lc, int r, int c);
    int dxx;
    int dyy;
    int dxy;
    int tr;
    int det4;
    dxx  = px_at(lc, r, c + 1) + px_at(lc, r, c - 1) - 2 * px_at(lc, r, c);
    dyy  = px_at(lc, r + 1, c) + px_at(lc, r - 1, c) - 2 * px_at(lc, r, c);
    dxy  = px_at(lc, r + 1, c + 1) + px_at(lc, r - 1, c - 1)
         - px_at(lc, r + 1, c - 1) - px_at(lc, r - 1, c + 1);
    tr   = dxx + dyy;
    det4 = 16 * dxx * dyy - dxy * dxy;
    return (det4 > 0) && (16 * edge_r * tr * tr < (edge_r + 1) * (edge_r + 1) * det4);
  endfunction

  // store order is row, then column, then lane 0 before lane 1
  task automatic build_expected(logic filt);
    logic [1:0] res;
    kp_rec_t    rec;
    exp_q.delete();
    for (int r = 1; r < img_h - 1; r++) begin
      for (int c = 1; c < img_w - 1; c++) begin
        for (int lane = 0; lane < 2; lane++) begin
          res = ext_check(lane + 1, r, c);
          if (res[1] && (!filt || edge_keep(lane + 1, r, c))) begin
            rec.row    = row_idx_t'(r);
            rec.col    = col_idx_t'(c);
            rec.layer  = 1'(lane);
            rec.is_min = res[0];
            exp_q.push_back(rec);
          end
        end
      end
    end
  endtask

  // ------------------------------------------------------------
  // stimulus and checks
  // ------------------------------------------------------------
  task automatic clear_image();
    foreach (px[l, r, c]) px[l][r][c] = '0;
  endtask

  task automatic pack_image();
    for (int r = 0; r < img_h; r++) begin
      for (int c = 0; c < img_w; c++) begin
        img[r].layer0[c] = px[0][r][c];
        img[r].layer1[c] = px[1][r][c];
        img[r].layer2[c] = px[2][r][c];
        img[r].layer3[c] = px[3][r][c];
      end
    end
  endtask

  task automatic compare_store();
    assert (int'(kp_count) == exp_q.size())
      else report_failure($sformatf("ERR kp_count got %h expected %h", kp_count, exp_q.size()));
    foreach (exp_q[i]) begin
      @(posedge clk);
      kp_rd_addr <= kp_addr_t'(i);
      @(negedge clk);
      assert (kp_rd_data == exp_q[i])
        else report_failure($sformatf("ERR kp_rd_data[%0d] got %h expected %h",
                                      i, kp_rd_data, exp_q[i]));
    end
  endtask

  task automatic run_scan(logic filt);
    int cycles;
    pack_image();
    build_expected(filt);
    @(posedge clk);
    filter_on <= filt;
    start     <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    cycles = 0;
    @(negedge clk);
    while (!done) begin
      assert (cycles < scan_cycles) else report_failure("scan did not raise done in time");
      @(negedge clk);
      cycles++;
    end
    compare_store();
  endtask

  task automatic check_empty();
    assert (kp_count == '0)
      else report_failure($sformatf("ERR kp_count got %h expected %h", kp_count, 9'h0));
  endtask

  task automatic check_single(int r, int c, logic layer, logic is_min);
    kp_rec_t want;
    want.row    = row_idx_t'(r);
    want.col    = col_idx_t'(c);
    want.layer  = layer;
    want.is_min = is_min;
    assert (kp_count == 9'd1)
      else report_failure($sformatf("ERR kp_count got %h expected %h", kp_count, 9'h1));
    @(posedge clk);
    kp_rd_addr <= '0;
    @(negedge clk);
    assert (kp_rd_data == want)
      else report_failure($sformatf("ERR kp_rd_data[0] got %h expected %h", kp_rd_data, want));
  endtask

  task automatic test_flat_image();
    clear_image();
    px[1][3][5] = pixel_t'(40);
    run_scan(1'b0);  // one entry that the next start must clear
    clear_image();
    run_scan(1'b0);
    check_empty();
    run_scan(1'b0);
    check_empty();
  endtask

  task automatic test_single_maximum();
    clear_image();
    px[1][3][5] = pixel_t'(40);
    run_scan(1'b0);
    check_single(3, 5, 1'b0, 1'b0);
    clear_image();
    px[2][3][5] = pixel_t'(40);
    run_scan(1'b0);
    check_single(3, 5, 1'b1, 1'b0);
  endtask

  task automatic test_contrast_limit();
    clear_image();
    px[1][3][5] = pixel_t'(-contrast_th);
    run_scan(1'b0);
    check_empty();
    px[1][3][5] = pixel_t'(-contrast_th - 1);
    run_scan(1'b0);
    check_single(3, 5, 1'b0, 1'b1);
  endtask

  task automatic test_edge_filter();
    clear_image();
    px[1][3][5] = pixel_t'(60);
    px[1][3][4] = pixel_t'(58);  // nearly flat along the row, steep across it
    px[1][3][6] = pixel_t'(58);
    run_scan(1'b0);
    check_single(3, 5, 1'b0, 1'b0);
    run_scan(1'b1);
    check_empty();
    clear_image();
    px[1][3][5] = pixel_t'(60);
    run_scan(1'b0);
    check_single(3, 5, 1'b0, 1'b0);
    run_scan(1'b1);
    check_single(3, 5, 1'b0, 1'b0);
  endtask

  task automatic test_random_images();
    int r0;
    int c0;
    for (int n = 0; n < n_random; n++) begin
      foreach (px[l, r, c]) px[l][r][c] = pixel_t'(int'(xorshift_next() % 201) - 100);
      r0 = 1 + int'(xorshift_next() % 6);
      c0 = 1 + int'(xorshift_next() % 14);
      // both lanes hit this pixel, so lane 0 must be stored first
      px[1][r0][c0] = pixel_t'(127);
      px[2][r0][c0] = pixel_t'(-128);
      run_scan(1'b0);
      run_scan(1'b1);
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    start      = 1'b0;
    filter_on  = 1'b0;
    kp_rd_addr = '0;
    clear_image();
    pack_image();
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (!done && !row_rd && kp_count == '0)
      else report_failure("outputs are not idle after reset");
    assert (u_dut.kp_req == 2'b00 && u_dut.kp_ack == 2'b00 && u_dut.lanes_busy == 2'b00)
      else report_failure("handshake signals are not idle after reset");
    test_flat_image();
    test_single_maximum();
    test_contrast_limit();
    test_edge_filter();
    test_random_images();
    $display("Done: no errors");
    $finish;
  end

  initial begin
    #(watchdog_ns);
    report_failure("watchdog timeout, the tests did not finish in time");
  end

endmodule

// File: verilog.f
rtl/image_pkg.sv
rtl/keypoint_pkg.sv
rtl/row_window.sv
rtl/extremum_detect.sv
rtl/edge_reject.sv
rtl/scan_lane.sv
rtl/keypoint_store.sv
rtl/scan_control.sv
rtl/keypoint_scan_top.sv
tests/tb_keypoint_scan.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_keypoint_scan
FILELIST  := verilog.f
BUILD_DIR := obj_dir
FLAGS     := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
